// File: alu/alu.sv
// 8-bit ALU of the execution unit
// Logic stage, adder operand select and a two-nibble adder with
// half carry and BCD carry detection; result and flags register on rdy
// Opcode bits [1:0] steer the logic stage, bits [3:2] the adder operand
`timescale 1ns/100ps

module alu import exec_pkg::*; (
  input  logic clk,
  input  logic rdy,
  alu_if.alu   bus
);

  logic [8:0] logic_res;  // Logic stage, bit 8 is the rotate-out bit
  logic [7:0] add_b;      // Second adder operand
  logic [4:0] sum_lo;     // Low nibble with carry
  logic [4:0] sum_hi;     // High nibble with carry
  logic [8:0] sum;
  logic       adder_ci;
  logic       hc9;        // Decimal low digit carry
  logic       co9;        // Decimal high digit carry
  logic       half_c;     // Carry into high nibble
  logic       ai7;        // Registered sign of ai
  logic       bi7;        // Registered sign of adder operand

  // Logic ops and pass have nothing to add, so carry in is blocked there
  assign adder_ci = (bus.right | (bus.op[3:2] == 2'b11)) ? 1'b0 : bus.ci;

  always_comb begin
    case (bus.op[1:0])
      2'b00:   logic_res = {1'b0, bus.ai | bus.bi};
      2'b01:   logic_res = {1'b0, bus.ai & bus.bi};
      2'b10:   logic_res = {1'b0, bus.ai ^ bus.bi};
      default: logic_res = {1'b0, bus.ai};
    endcase

    // Rotate right, old bit 0 lands in bit 8 as carry out
    if (bus.right) begin
      logic_res = {bus.ai[0], bus.ci, bus.ai[7:1]};
    end
  end

  // Adder operand select
  always_comb begin
    case (bus.op[3:2])
      2'b00:   add_b = bus.bi;          // Add
      2'b01:   add_b = ~bus.bi;         // Subtract, carry is not-borrow
      2'b10:   add_b = logic_res[7:0];  // Double for left shifts
      default: add_b = 8'h00;           // Logic result through
    endcase
  end

  // Low digit above 9 counts as carry when decimal
  assign hc9    = bus.bcd & (sum_lo[3:1] >= 3'd5);
  assign half_c = sum_lo[4] | hc9;

  // Same check on the high digit
  assign co9 = bus.bcd & (sum_hi[3:1] >= 3'd5);

  // Two nibble adds so the half carry is visible
  always_comb begin
    sum_lo = {1'b0, logic_res[3:0]} + {1'b0, add_b[3:0]} + {4'b0, adder_ci};
    sum_hi = logic_res[8:4] + {1'b0, add_b[7:4]} + {4'b0, half_c};
  end

  assign sum = {sum_hi, sum_lo[3:0]};

  // Result and flag register, holds while rdy is low
  always_ff @(posedge clk) begin
    if (rdy) begin
      ai7     <= bus.ai[7];
      bi7     <= add_b[7];
      bus.out <= sum[7:0];
      bus.co  <= sum[8] | co9;
      bus.n   <= sum[7];
      bus.hc  <= half_c;
    end
  end

  // Overflow from operand signs and the carry into bit 7
  assign bus.v = ai7 ^ bi7 ^ bus.co ^ bus.n;
  assign bus.z = ~|bus.out;

endmodule

// File: alu/alu_ctrl.sv
// Instruction decode and issue for the execution unit
// Maps each instruction to ALU controls, picks operands and keeps the
// one instruction that waits for writeback; a pending result or flag
// is forwarded so a new instruction may issue every cycle
`timescale 1ns/100ps

module alu_ctrl import exec_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rdy,
  input  logic       start,
  input  exec_op_e   exec_op,
  input  logic [7:0] operand,
  input  logic [7:0] acc,
  input  logic [7:0] fwd_acc,   // Corrected pending result
  input  logic       flag_c,
  input  logic       flag_d,
  alu_if.ctrl        bus,
  output logic       wb_valid,
  output exec_op_e   wb_op
);

  logic       pend_wr_a;  // Pending instruction writes the accumulator
  logic       eff_c;      // Carry as the next instruction must see it
  logic       eff_d;
  logic [7:0] a_src;

  // Work out what the pending instruction will write
  always_comb begin
    pend_wr_a = 1'b0;
    eff_c     = flag_c;
    eff_d     = flag_d;
    if (wb_valid) begin
      case (wb_op)
        OP_ADC, OP_SBC, OP_ASL, OP_LSR, OP_ROL, OP_ROR: begin
          pend_wr_a = 1'b1;
          eff_c     = bus.co;
        end
        OP_CMP:                 eff_c = bus.co;  // Carry only
        OP_AND, OP_ORA, OP_EOR,
        OP_LDA:                 pend_wr_a = 1'b1;
        OP_SEC:                 eff_c = 1'b1;
        OP_CLC:                 eff_c = 1'b0;
        OP_SED:                 eff_d = 1'b1;
        OP_CLD:                 eff_d = 1'b0;
        default: ;
      endcase
    end
  end

  assign a_src = pend_wr_a ? fwd_acc : acc;

  // Instruction to ALU control mapping
  always_comb begin
    bus.op    = ALU_PASS;
    bus.right = 1'b0;
    bus.ai    = a_src;
    bus.bi    = operand;
    bus.ci    = 1'b0;
    bus.bcd   = 1'b0;
    case (exec_op)
      OP_ADC: begin
        bus.op  = ALU_ADD;
        bus.ci  = eff_c;
        bus.bcd = eff_d;  // Only ADC is decimal
      end
      OP_SBC: begin
        bus.op = ALU_SUB;
        bus.ci = eff_c;
      end
      OP_CMP: begin
        bus.op = ALU_SUB;
        bus.ci = 1'b1;    // No borrow
      end
      OP_AND: bus.op = ALU_AND;
      OP_ORA: bus.op = ALU_OR;
      OP_EOR: bus.op = ALU_XOR;
      OP_LDA: bus.ai = operand;  // Straight through
      OP_ASL: bus.op = ALU_DBL;
      OP_ROL: begin
        bus.op = ALU_DBL;
        bus.ci = eff_c;
      end
      OP_LSR: bus.right = 1'b1;
      OP_ROR: begin
        bus.right = 1'b1;
        bus.ci    = eff_c;
      end
      default: ;  // Flag ops do not use the ALU result
    endcase
  end

  // One-entry in-flight register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      wb_op    <= OP_CLD;
    end else if (rdy) begin
      wb_valid <= start;
      if (start) begin
        wb_op <= exec_op;
      end
    end
  end

endmodule

// File: common/alu_if.sv
// Bundle between the instruction controller and the ALU
// ctrl side drives function select and operands, alu side returns
// the registered result and flags; writeback listens on the alu side
`timescale 1ns/100ps

interface alu_if import exec_pkg::*; ();

  alu_op_e     op;     // ALU function
  logic        right;  // Rotate right through ci
  logic [7:0]  ai;     // Left operand, accumulator or forwarded value
  logic [7:0]  bi;     // Right operand
  logic        ci;     // Carry in
  logic        bcd;    // Decimal carry detection

  logic [7:0]  out;    // Registered result
  logic        co;     // Carry out, decimal carry when bcd
  logic        v;
  logic        z;
  logic        n;
  logic        hc;     // Half carry, low digit overflow

  // Instruction decode side
  modport ctrl (
    output op,
    output right,
    output ai,
    output bi,
    output ci,
    output bcd,
    input  co          // Needed for carry forwarding
  );

  // ALU side
  modport alu (
    input  op,
    input  right,
    input  ai,
    input  bi,
    input  ci,
    input  bcd,
    output out,
    output co,
    output v,
    output z,
    output n,
    output hc
  );

endinterface

// File: common/exec_pkg.sv
// Shared types and constants for the accumulator execution unit
// ALU opcodes keep the classic 6502 core encoding
// Pull in with a wildcard import in the module header
package exec_pkg;

  // ALU function select, bits [3:2] pick the adder operand
  // and bits [1:0] pick the logic stage result
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0011,  // AI + BI
    ALU_SUB  = 4'b0111,  // AI + ~BI
    ALU_DBL  = 4'b1011,  // AI + AI
    ALU_OR   = 4'b1100,
    ALU_AND  = 4'b1101,
    ALU_XOR  = 4'b1110,
    ALU_PASS = 4'b1111   // AI, or rotate right
  } alu_op_e;

  // Instructions accepted on a start strobe
  typedef enum logic [3:0] {
    OP_ADC,
    OP_SBC,
    OP_CMP,
    OP_AND,
    OP_ORA,
    OP_EOR,
    OP_LDA,
    OP_ASL,
    OP_LSR,
    OP_ROL,
    OP_ROR,
    OP_SEC,
    OP_CLC,
    OP_SED,
    OP_CLD
  } exec_op_e;

  // Decimal digit correction, added per nibble after a BCD carry
  localparam logic [7:0] BCD_LO_ADJ = 8'h06;  // Low digit
  localparam logic [7:0] BCD_HI_ADJ = 8'h60;  // High digit

endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert -Wno-fatal --top-module exec_tb -f vlog.f -o exec_sim \
  && ./obj_dir/exec_sim > sim.log 2>&1 \
  || echo "TEST FAIL" >> sim.log
cat sim.log
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

// File: src/accum_status.sv
// Accumulator and status flags, written one cycle after issue
// Decodes per-instruction write masks, applies the decimal digit
// correction after ADC with D set, and pulses done for each writeback
// fwd_acc returns the corrected result to the controller for forwarding
`timescale 1ns/100ps

module accum_status import exec_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rdy,
  input  logic       wb_valid,
  input  exec_op_e   wb_op,
  alu_if.alu         bus,       // Only the result side is read
  output logic [7:0] acc,
  output logic       flag_c,
  output logic       flag_z,
  output logic       flag_v,
  output logic       flag_n,
  output logic       flag_d,
  output logic       done,
  output logic [7:0] fwd_acc
);

  logic       dec_fix;    // Decimal ADC result needs correction
  logic [3:0] lo_fix;
  logic [3:0] hi_fix;
  logic       res_z;
  logic       res_n;
  logic       wr_a;
  logic       wr_c;
  logic       wr_zn;
  logic       wr_v;
  logic       c_val;

  // D still holds the value the ADC issued with
  assign dec_fix = (wb_op == OP_ADC) && flag_d;

  // Per nibble, no carry between digits
  assign lo_fix  = bus.out[3:0] + (bus.hc ? BCD_LO_ADJ[3:0] : 4'h0);
  assign hi_fix  = bus.out[7:4] + (bus.co ? BCD_HI_ADJ[7:4] : 4'h0);
  assign fwd_acc = dec_fix ? {hi_fix, lo_fix} : bus.out;

  // Binary results keep the ALU flags
  assign res_z = dec_fix ? ~|fwd_acc : bus.z;
  assign res_n = dec_fix ? fwd_acc[7] : bus.n;

  // Write masks
  always_comb begin
    wr_a  = 1'b0;
    wr_c  = 1'b0;
    wr_zn = 1'b0;
    wr_v  = 1'b0;
    c_val = bus.co;
    case (wb_op)
      OP_ADC, OP_SBC: begin
        wr_a  = 1'b1;
        wr_c  = 1'b1;
        wr_zn = 1'b1;
        wr_v  = 1'b1;
      end
      OP_CMP: begin
        wr_c  = 1'b1;
        wr_zn = 1'b1;
      end
      OP_ASL, OP_LSR, OP_ROL, OP_ROR: begin
        wr_a  = 1'b1;
        wr_c  = 1'b1;  // Shifted-out bit
        wr_zn = 1'b1;
      end
      OP_AND, OP_ORA, OP_EOR, OP_LDA: begin
        wr_a  = 1'b1;
        wr_zn = 1'b1;
      end
      OP_SEC, OP_CLC: begin
        wr_c  = 1'b1;
        c_val = (wb_op == OP_SEC);
      end
      default: ;  // SED and CLD handled below
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc    <= 8'h00;
      flag_c <= 1'b0;
      flag_z <= 1'b0;
      flag_v <= 1'b0;
      flag_n <= 1'b0;
      flag_d <= 1'b0;
    end else if (rdy && wb_valid) begin
      if (wr_a) acc <= fwd_acc;
      if (wr_c) flag_c <= c_val;
      if (wr_v) flag_v <= bus.v;
      if (wr_zn) begin
        flag_z <= res_z;
        flag_n <= res_n;
      end
      if (wb_op == OP_SED) flag_d <= 1'b1;
      if (wb_op == OP_CLD) flag_d <= 1'b0;
    end
  end

  // One cycle per writeback
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= rdy && wb_valid;
    end
  end

endmodule

// File: src/exec_top.sv
// Top level of the accumulator execution unit
// One instruction per start strobe, everything advances on rdy
// Result shows in acc and flags two accepted edges after start
`timescale 1ns/100ps

module exec_top import exec_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rdy,
  input  logic       start,
  input  exec_op_e   exec_op,
  input  logic [7:0] operand,
  output logic [7:0] acc,
  output logic       flag_c,
  output logic       flag_z,
  output logic       flag_v,
  output logic       flag_n,
  output logic       flag_d,
  output logic       done
);

  logic       wb_valid;
  exec_op_e   wb_op;
  logic [7:0] fwd_acc;

  alu_if u_bus ();

  // Decode, operand select and forwarding
  alu_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .rdy      (rdy),
    .start    (start),
    .exec_op  (exec_op),
    .operand  (operand),
    .acc      (acc),
    .fwd_acc  (fwd_acc),
    .flag_c   (flag_c),
    .flag_d   (flag_d),
    .bus      (u_bus.ctrl),
    .wb_valid (wb_valid),
    .wb_op    (wb_op)
  );

  alu u_alu (
    .clk (clk),
    .rdy (rdy),
    .bus (u_bus.alu)
  );

  // Writeback stage
  accum_status u_wb (
    .clk      (clk),
    .rst_n    (rst_n),
    .rdy      (rdy),
    .wb_valid (wb_valid),
    .wb_op    (wb_op),
    .bus      (u_bus.alu),
    .acc      (acc),
    .flag_c   (flag_c),
    .flag_z   (flag_z),
    .flag_v   (flag_v),
    .flag_n   (flag_n),
    .flag_d   (flag_d),
    .done     (done),
    .fwd_acc  (fwd_acc)
  );

endmodule

// File: test/exec_tb.sv
// Testbench for exec_top
// LFSR-driven instruction streams with a sequential model of A and flags;
// expected states queue up at issue and are matched on each done pulse
// Runs reset, directed, random binary, decimal ADC and rdy stall phases
`timescale 1ns/100ps

module exec_tb import exec_pkg::*; ();

  localparam int N_BIN    = 200;  // Random binary ops
  localparam int N_DEC    = 120;  // Decimal phase ops
  localparam int N_STALL  = 200;  // Ops with rdy gaps
  localparam int N_INSTR  = 8 + N_BIN + 3 + N_DEC + 4 + N_STALL;
  localparam int WATCHDOG_CYCLES = N_INSTR * 4 + 50;

  logic       clk;
  logic       rst_n;
  logic       rdy;
  logic       start;
  exec_op_e   exec_op;
  logic [7:0] operand;
  logic [7:0] acc;
  logic       flag_c;
  logic       flag_z;
  logic       flag_v;
  logic       flag_n;
  logic       flag_d;
  logic       done;

  logic [31:0] lfsr = 32'hbbe6;

  // Sequential model that runs ahead of the DUT by the in-flight work
  logic [7:0] m_acc = 8'h00;
  logic       m_c = 1'b0;
  logic       m_z = 1'b0;
  logic       m_v = 1'b0;
  logic       m_n = 1'b0;
  logic       m_d = 1'b0;
  logic       m_v_known = 1'b1;  // Cleared by decimal ADC

  // Expected state per accepted start in issue order
  logic [7:0] q_acc[$];
  logic [5:0] q_flags[$];        // {c, z, v, n, d, v_known}
  int         q_due[$];          // Accepted edge of the writeback

  // Last committed expected state checked at every negedge
  logic [7:0] chk_acc = 8'h00;
  logic       chk_c = 1'b0;
  logic       chk_z = 1'b0;
  logic       chk_v = 1'b0;
  logic       chk_n = 1'b0;
  logic       chk_d = 1'b0;
  logic       chk_v_known = 1'b1;

  int edges  = 0;                // Accepted edges since reset

  tb_clock u_clk (.clk (clk));

  exec_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .rdy     (rdy),
    .start   (start),
    .exec_op (exec_op),
    .operand (operand),
    .acc     (acc),
    .flag_c  (flag_c),
    .flag_z  (flag_z),
    .flag_v  (flag_v),
    .flag_n  (flag_n),
    .flag_d  (flag_d),
    .done    (done)
  );

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    val = 8'h00;
    for (int i = 0; i < n; i++) begin
      val  = {val[6:0], lfsr[31]};  // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic take_bcd(output logic [7:0] val);
    logic [7:0] hi;
    logic [7:0] lo;
    take_bits(4, hi);
    take_bits(4, lo);
    val = {hi[3:0] % 4'd10, lo[3:0] % 4'd10};
  endtask

  function automatic logic bcd_valid(input logic [7:0] v);
    return (v[7:4] <= 4'd9) && (v[3:0] <= 4'd9);
  endfunction

  // Instruction rules applied in issue order
  task automatic model_exec(input exec_op_e op, input logic [7:0] b);
    logic [7:0] res;
    logic [8:0] sum9;
    logic       wr_a;
    logic       wr_zn;
    int         diff;
    int         lo;
    int         hi;
    res   = m_acc;
    wr_a  = 1'b1;
    wr_zn = 1'b1;
    case (op)
      OP_ADC: begin
        if (m_d) begin
          lo = int'(m_acc[3:0]) + int'(b[3:0]) + int'(m_c);
          hi = int'(m_acc[7:4]) + int'(b[7:4]) + ((lo > 9) ? 1 : 0);
          if (lo > 9) lo = lo - 10;
          m_c = (hi > 9);  // Decimal carry
          if (hi > 9) hi = hi - 10;
          res = 8'(hi * 16 + lo);
          m_v_known = 1'b0;
        end else begin
          sum9 = {1'b0, m_acc} + {1'b0, b} + {8'h00, m_c};
          res  = sum9[7:0];
          m_v  = (m_acc[7] == b[7]) && (res[7] != m_acc[7]);
          m_c  = sum9[8];
          m_v_known = 1'b1;
        end
      end
      OP_SBC: begin
        diff = int'(m_acc) - int'(b) - (m_c ? 0 : 1);  // Borrow is not C
        res  = 8'(diff);
        m_v  = (m_acc[7] != b[7]) && (res[7] != m_acc[7]);
        m_c  = (diff >= 0);
        m_v_known = 1'b1;
      end
      OP_CMP: begin
        diff = int'(m_acc) - int'(b);
        res  = 8'(diff);
        m_c  = (diff >= 0);
        wr_a = 1'b0;   // A untouched
      end
      OP_AND: res = m_acc & b;
      OP_ORA: res = m_acc | b;
      OP_EOR: res = m_acc ^ b;
      OP_LDA: res = b;
      OP_ASL: begin
        res = {m_acc[6:0], 1'b0};
        m_c = m_acc[7];
      end
      OP_ROL: begin
        res = {m_acc[6:0], m_c};
        m_c = m_acc[7];
      end
      OP_LSR: begin
        res = {1'b0, m_acc[7:1]};
        m_c = m_acc[0];
      end
      OP_ROR: begin
        res = {m_c, m_acc[7:1]};
        m_c = m_acc[0];
      end
      default: begin  // Single flag ops
        wr_a  = 1'b0;
        wr_zn = 1'b0;
        if (op == OP_SEC) m_c = 1'b1;
        if (op == OP_CLC) m_c = 1'b0;
        if (op == OP_SED) m_d = 1'b1;
        if (op == OP_CLD) m_d = 1'b0;
      end
    endcase
    if (wr_zn) begin
      m_z = (res == 8'h00);
      m_n = res[7];
    end
    if (wr_a) m_acc = res;
  endtask

  // Drives one cycle after the edge and feeds accepted starts to the model
  task automatic drive_cycle(input logic rdy_v, input logic start_v,
                             input exec_op_e op, input logic [7:0] b);
    @(posedge clk);
    #5;
    rdy     = rdy_v;
    start   = start_v;
    exec_op = op;
    operand = b;
    if (rdy_v && start_v) begin
      model_exec(op, b);
      q_acc.push_back(m_acc);
      q_flags.push_back({m_c, m_z, m_v, m_n, m_d, m_v_known});
      q_due.push_back(edges + 2);  // Start edge plus writeback edge
    end
  endtask

  task automatic issue_spaced(input exec_op_e op, input logic [7:0] b);
    drive_cycle(1'b1, 1'b1, op, b);
    drive_cycle(1'b1, 1'b0, op, b);
    drive_cycle(1'b1, 1'b0, op, b);
  endtask

  always @(posedge clk) begin
    if (rst_n && rdy) edges <= edges + 1;
  end

  // Retire one expected state per done pulse in mid-cycle
  always begin
    @(posedge clk);
    #10;
    if (done) begin
      assert (q_due.size() != 0)
      else fail_now("done pulsed with no instruction waiting for writeback");
      if (q_due.size() != 0) begin
        assert (q_due[0] == edges)
        else fail_now($sformatf("Mismatch at %0t: writeback on accepted edge %0d, expected %0d",
                                $time, edges, q_due[0]));
        chk_acc = q_acc.pop_front();
        {chk_c, chk_z, chk_v, chk_n, chk_d, chk_v_known} = q_flags.pop_front();
        void'(q_due.pop_front());
      end
    end
  end

  // Outputs hold the committed state at all times including reset
  assert property (@(negedge clk) acc == chk_acc)
  else fail_now($sformatf("Mismatch at %0t: acc is %h, expected %h", $time, acc, chk_acc));

  assert property (@(negedge clk)
    {flag_c, flag_z, flag_n, flag_d} == {chk_c, chk_z, chk_n, chk_d})
  else fail_now($sformatf("Mismatch at %0t: CZND is %b, expected %b", $time,
                          {flag_c, flag_z, flag_n, flag_d}, {chk_c, chk_z, chk_n, chk_d}));

  assert property (@(negedge clk) !chk_v_known || (flag_v == chk_v))
  else fail_now($sformatf("Mismatch at %0t: V is %b, expected %b", $time, flag_v, chk_v));

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    fail_now($sformatf("Timeout, the test did not finish in %0d cycles", WATCHDOG_CYCLES));
  end

  initial begin
    logic [7:0] r;
    logic [7:0] b;
    exec_op_e   op;
    rst_n   = 1'b0;
    rdy     = 1'b1;
    start   = 1'b0;
    exec_op = OP_LDA;
    operand = 8'h00;
    repeat (8) @(posedge clk);
    #5 rst_n = 1'b1;

    // Directed ops issued one at a time
    issue_spaced(OP_LDA, 8'h50);
    issue_spaced(OP_ADC, 8'h50);   // Signed overflow
    issue_spaced(OP_SEC, 8'h00);
    issue_spaced(OP_SBC, 8'h01);
    issue_spaced(OP_CMP, 8'h9f);   // Equal
    issue_spaced(OP_ASL, 8'h00);
    issue_spaced(OP_ROR, 8'h00);
    issue_spaced(OP_LDA, 8'h00);

    // Mostly back to back binary mix over encodings 0..12 (ADC..CLC)
    for (int i = 0; i < N_BIN; i++) begin
      take_bits(4, r);
      take_bits(8, b);
      op = exec_op_e'(r[3:0] % 4'd13);
      drive_cycle(1'b1, 1'b1, op, b);
      take_bits(2, r);
      if (r == 8'd0) drive_cycle(1'b1, 1'b0, op, b);  // Idle gap
    end

    // Decimal ADC with A kept valid BCD
    drive_cycle(1'b1, 1'b1, OP_LDA, 8'h58);
    drive_cycle(1'b1, 1'b1, OP_SED, 8'h00);
    drive_cycle(1'b1, 1'b1, OP_ADC, 8'h46);  // D still in flight from SED
    for (int i = 0; i < N_DEC; i++) begin
      take_bits(2, r);
      take_bcd(b);
      if (!bcd_valid(m_acc) || r == 8'd0) op = OP_LDA;
      else if (r == 8'd3) op = b[0] ? OP_SEC : OP_CLC;
      else op = OP_ADC;
      drive_cycle(1'b1, 1'b1, op, b);
    end
    drive_cycle(1'b1, 1'b1, OP_LDA, 8'h09);
    drive_cycle(1'b1, 1'b1, OP_CLC, 8'h00);
    drive_cycle(1'b1, 1'b1, OP_CLD, 8'h00);
    drive_cycle(1'b1, 1'b1, OP_ADC, 8'h01);  // Binary again right behind CLD

    // rdy gaps with a start held high
    for (int i = 0; i < N_STALL; i++) begin
      take_bits(2, r);
      if (r == 8'd0) begin
        take_bits(4, r);
        take_bits(8, b);
        drive_cycle(1'b0, 1'b1, exec_op_e'(r[3:0] % 4'd13), b);
      end
      take_bits(4, r);
      take_bits(8, b);
      drive_cycle(1'b1, 1'b1, exec_op_e'(r[3:0] % 4'd13), b);
    end

    // Drain the pipeline
    while (q_due.size() != 0) drive_cycle(1'b1, 1'b0, OP_LDA, 8'h00);
    drive_cycle(1'b1, 1'b0, OP_LDA, 8'h00);
    drive_cycle(1'b1, 1'b0, OP_LDA, 8'h00);

    $display("TEST PASS");
    $finish;
  end

endmodule

// File: test/tb_clock.sv
// Free-running clock for the execution unit testbench
// 40 ns period, starts low
`timescale 1ns/100ps

module tb_clock (
  output logic clk
);

  initial clk = 1'b0;

  always #20 clk = ~clk;  // Half period

endmodule

// File: vlog.f
common/exec_pkg.sv
common/alu_if.sv
alu/alu.sv
alu/alu_ctrl.sv
src/accum_status.sv
src/exec_top.sv
test/tb_clock.sv
test/exec_tb.sv
